// ==== engine_alu_ops_config.sv ====
// AXI4-Lite register slave for the ALU configuration
// Generates the one-cycle accumulator clear pulse
`timescale 1ns/1ns
`default_nettype none

module engine_alu_ops_config (
  input  logic                        ap_clk,
  input  logic                        areset,
  // Write address and data
  input  logic                        awvalid,
  output logic                        awready,
  input  engine_alu_pkg::reg_addr_t   awaddr,
  input  logic                        wvalid,
  output logic                        wready,
  input  logic [31:0]                 wdata,
  // Write response
  output logic                        bvalid,
  input  logic                        bready,
  output logic [1:0]                  bresp,
  // Read address and data
  input  logic                        arvalid,
  output logic                        arready,
  input  engine_alu_pkg::reg_addr_t   araddr,
  output logic                        rvalid,
  input  logic                        rready,
  output logic [31:0]                 rdata,
  output logic [1:0]                  rresp,
  // Configuration to the kernel
  output engine_alu_pkg::alu_config_t cfg,
  output logic                        clear
);

  import engine_alu_pkg::*;

  logic        write_fire;
  logic        read_fire;
  logic [31:0] read_value;

  // Address and data taken together, one write outstanding
  assign write_fire = awvalid & wvalid & ~bvalid;
  assign awready    = write_fire;
  assign wready     = write_fire;

  // One read outstanding
  assign read_fire = arvalid & ~rvalid;
  assign arready   = read_fire;

  // Always OKAY
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // ----------------------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      cfg   <= '0;
      clear <= 1'b0;
    end else begin
      // Pulse lasts one cycle unless rewritten
      clear <= 1'b0;
      if (write_fire) begin
        case (awaddr)
          REG_OPERATION:   cfg.alu_operation <= alu_op_t'(wdata[2:0]);
          REG_CONST_VALUE: cfg.const_value   <= wdata;
          REG_CONST_MASK:  cfg.const_mask    <= wdata[NUM_FIELDS-1:0];
          REG_ALU_MASK:    cfg.alu_mask      <= wdata[NUM_FIELDS-1:0];
          REG_OPS_MASK:    cfg.ops_mask      <= wdata[NUM_FIELDS*NUM_FIELDS-1:0];
          REG_CLEAR:       clear             <= wdata[0];
          default: ;
        endcase
      end
    end
  end

  // Write response
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      bvalid <= 1'b0;
    end else if (write_fire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Register reads
  // ----------------------------------------------------------------------

  // Unmapped and clear offsets read zero
  always_comb begin
    read_value = '0;
    case (araddr)
      REG_OPERATION:   read_value[2:0]                       = cfg.alu_operation;
      REG_CONST_VALUE: read_value                            = cfg.const_value;
      REG_CONST_MASK:  read_value[NUM_FIELDS-1:0]            = cfg.const_mask;
      REG_ALU_MASK:    read_value[NUM_FIELDS-1:0]            = cfg.alu_mask;
      REG_OPS_MASK:    read_value[NUM_FIELDS*NUM_FIELDS-1:0] = cfg.ops_mask;
      default: ;
    endcase
  end

  // Read data captured at the address handshake
  always_ff @(posedge ap_clk) begin
    if (read_fire) begin
      rdata <= read_value;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      rvalid <= 1'b0;
    end else if (read_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== engine_alu_ops_kernel.sv ====
// Three-stage ALU pipeline: operand crossbar, arithmetic, output merge
// Holds the running accumulator for ACC
`timescale 1ns/1ns
`default_nettype none

module engine_alu_ops_kernel (
  input  logic                           ap_clk,
  input  logic                           areset,
  input  logic                           clear,
  input  engine_alu_pkg::alu_config_t    cfg,
  input  logic                           accept,
  input  engine_alu_pkg::engine_packet_t data_in,
  output logic                           result_valid,
  output engine_alu_pkg::engine_packet_t result
);

  import engine_alu_pkg::*;

  localparam int IDX_W = $clog2(NUM_FIELDS);

  // Stage 1, operands and the config slice that rides along
  engine_packet_t   operands;
  engine_packet_t   ops_s1;
  alu_op_t          op_s1;
  field_mask_t      alu_mask_s1;
  logic             valid_s1;

  // Stage 2, ALU result and delayed operand copy
  engine_packet_t   ops_s2;
  field_t           result_s2;
  logic             valid_s2;

  // Operand pair and accumulate selection
  logic [IDX_W-1:0] k_pair;
  logic             have_pair;
  logic [IDX_W-1:0] k_acc;
  logic             have_acc;
  field_t           opnd_a;
  field_t           opnd_b;
  field_t           acc_reg;
  field_t           acc_sum;
  field_t           alu_value;

  // ----------------------------------------------------------------------
  // Stage 1: operand select
  // ----------------------------------------------------------------------

  // Constant first, then highest selected input, else invalid zero
  always_comb begin
    operands = '0;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      operands.field_state[i] = SEQUENCE_INVALID;
      if (cfg.const_mask[i]) begin
        operands.field[i]       = cfg.const_value;
        operands.field_state[i] = SEQUENCE_RUNNING;
      end else begin
        for (int j = 0; j < NUM_FIELDS; j++) begin
          if (cfg.ops_mask[i][j]) begin
            operands.field[i]       = data_in.field[j];
            operands.field_state[i] = data_in.field_state[j];
          end
        end
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    ops_s1      <= operands;
    op_s1       <= cfg.alu_operation;
    alu_mask_s1 <= cfg.alu_mask;
  end

  // ----------------------------------------------------------------------
  // Stage 2: arithmetic
  // ----------------------------------------------------------------------

  // Highest mask bit, pair ops stop one short of the top field
  always_comb begin
    have_pair = 1'b0;
    k_pair    = '0;
    have_acc  = 1'b0;
    k_acc     = '0;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      if (alu_mask_s1[i]) begin
        have_acc = 1'b1;
        k_acc    = IDX_W'(i);
        if (i < NUM_FIELDS - 1) begin
          have_pair = 1'b1;
          k_pair    = IDX_W'(i);
        end
      end
    end
  end

  assign opnd_a  = ops_s1.field[k_pair];
  assign opnd_b  = ops_s1.field[k_pair + 1'b1];
  assign acc_sum = acc_reg + ops_s1.field[k_acc];

  always_comb begin
    alu_value = ops_s1.field[0];
    case (op_s1)
      ALU_ADD: if (have_pair) alu_value = opnd_a + opnd_b;
      // Absolute difference
      ALU_SUB: if (have_pair) alu_value = (opnd_a > opnd_b) ? opnd_a - opnd_b
                                                             : opnd_b - opnd_a;
      // Low word of the product
      ALU_MUL: if (have_pair) alu_value = opnd_a * opnd_b;
      ALU_ACC: alu_value = have_acc ? acc_sum : acc_reg;
      // NOP, DIV and unused codes pass operand 0
      default: ;
    endcase
  end

  // Accumulator moves only on a valid ACC packet
  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      acc_reg <= '0;
    end else if (valid_s1 && op_s1 == ALU_ACC && have_acc) begin
      acc_reg <= acc_sum;
    end
  end

  always_ff @(posedge ap_clk) begin
    result_s2 <= alu_value;
    ops_s2    <= ops_s1;
  end

  // ----------------------------------------------------------------------
  // Stage 3: merge result into field 0
  // ----------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    result.field[0]              <= result_s2;
    result.field[NUM_FIELDS-1:1] <= ops_s2.field[NUM_FIELDS-1:1];
    result.field_state           <= ops_s2.field_state;
  end

  // Valid shift, three cycles from accept
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      valid_s1     <= 1'b0;
      valid_s2     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      valid_s1     <= accept;
      valid_s2     <= valid_s1;
      result_valid <= valid_s2;
    end
  end

endmodule

`default_nettype wire

// ==== engine_alu_ops_result_buffer.sv ====
// Result FIFO behind the kernel with credit-based input ready
// Issues the input accept pulse for the kernel
`timescale 1ns/1ns
`default_nettype none

module engine_alu_ops_result_buffer #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                           ap_clk,
  input  logic                           areset,
  input  logic                           in_valid,
  output logic                           in_ready,
  output logic                           accept,
  input  logic                           result_valid,
  input  engine_alu_pkg::engine_packet_t result,
  output logic                           out_valid,
  input  logic                           out_ready,
  output engine_alu_pkg::engine_packet_t out_packet
);

  import engine_alu_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  engine_packet_t   mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  // Kernel holds at most three packets
  logic [1:0]       in_flight;
  logic [1:0]       in_flight_next;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign accept     = in_valid & in_ready;
  assign push       = result_valid;
  assign pop        = out_valid & out_ready;
  assign out_packet = mem[rd_ptr];

  // Occupancy and credits for the next cycle
  always_comb begin
    count_next     = count + CNT_W'(push) - CNT_W'(pop);
    in_flight_next = in_flight + 2'(accept) - 2'(result_valid);
  end

  // Storage, credits guarantee a free slot on every push
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= result;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_flight <= '0;
      out_valid <= 1'b0;
      in_ready  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count     <= count_next;
      in_flight <= in_flight_next;
      out_valid <= (count_next != '0);
      // Room for stored plus in-flight packets
      in_ready  <= (32'(count_next) + 32'(in_flight_next)) < FIFO_DEPTH;
    end
  end

endmodule

`default_nettype wire

// ==== engine_alu_ops_top.sv ====
// ALU stage top level with register slave, kernel and result buffer
`timescale 1ns/1ns
`default_nettype none

module engine_alu_ops_top #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                           ap_clk,
  input  logic                           areset,
  // AXI4-Lite configuration port
  input  logic                           awvalid,
  output logic                           awready,
  input  engine_alu_pkg::reg_addr_t      awaddr,
  input  logic                           wvalid,
  output logic                           wready,
  input  logic [31:0]                    wdata,
  output logic                           bvalid,
  input  logic                           bready,
  output logic [1:0]                     bresp,
  input  logic                           arvalid,
  output logic                           arready,
  input  engine_alu_pkg::reg_addr_t      araddr,
  output logic                           rvalid,
  input  logic                           rready,
  output logic [31:0]                    rdata,
  output logic [1:0]                     rresp,
  // Packet streams
  input  logic                           in_valid,
  output logic                           in_ready,
  input  engine_alu_pkg::engine_packet_t in_packet,
  output logic                           out_valid,
  input  logic                           out_ready,
  output engine_alu_pkg::engine_packet_t out_packet
);

  import engine_alu_pkg::*;

  alu_config_t    cfg;
  logic           clear;
  logic           accept;
  logic           result_valid;
  engine_packet_t result;

  engine_alu_ops_config u_config (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .cfg     (cfg),
    .clear   (clear)
  );

  engine_alu_ops_kernel u_kernel (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .clear        (clear),
    .cfg          (cfg),
    .accept       (accept),
    .data_in      (in_packet),
    .result_valid (result_valid),
    .result       (result)
  );

  // Buffer owns the input handshake
  engine_alu_ops_result_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_result_buffer (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .accept       (accept),
    .result_valid (result_valid),
    .result       (result),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_packet   (out_packet)
  );

endmodule

`default_nettype wire

// ==== engine_alu_pkg.sv ====
// Shared packet, field state and configuration types for the ALU stage
// Operation encoding and AXI4-Lite register offsets
`default_nettype none

package engine_alu_pkg;

  // ----------------------------------------------------------------------
  // Packet layout
  // ----------------------------------------------------------------------

  // Data fields per packet
  localparam int NUM_FIELDS = 4;

  // One data field
  typedef logic [31:0] field_t;

  // Sequence state tag carried by every field
  typedef enum logic [1:0] {
    SEQUENCE_INVALID = 2'd0,
    SEQUENCE_RUNNING = 2'd1,
    SEQUENCE_BREAK   = 2'd2,
    SEQUENCE_END     = 2'd3
  } field_state_t;

  // Fields and their tags, 136 bits
  typedef struct packed {
    field_t       [NUM_FIELDS-1:0] field;
    field_state_t [NUM_FIELDS-1:0] field_state;
  } engine_packet_t;

  // ----------------------------------------------------------------------
  // ALU configuration
  // ----------------------------------------------------------------------

  // Codes 6 and 7 are unused and act as NOP
  typedef enum logic [2:0] {
    ALU_NOP = 3'd0,
    ALU_ADD = 3'd1,
    ALU_SUB = 3'd2,
    ALU_MUL = 3'd3,
    ALU_ACC = 3'd4,
    ALU_DIV = 3'd5
  } alu_op_t;

  // One bit per field
  typedef logic [NUM_FIELDS-1:0] field_mask_t;

  // Full configuration word, 59 bits
  typedef struct packed {
    alu_op_t                      alu_operation;
    field_mask_t                  alu_mask;
    field_mask_t                  const_mask;
    field_t                       const_value;
    // Row i picks the source field of operand i
    field_mask_t [NUM_FIELDS-1:0] ops_mask;
  } alu_config_t;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------

  typedef logic [7:0] reg_addr_t;

  localparam reg_addr_t REG_OPERATION   = 8'h00;
  localparam reg_addr_t REG_CONST_VALUE = 8'h04;
  localparam reg_addr_t REG_CONST_MASK  = 8'h08;
  localparam reg_addr_t REG_ALU_MASK    = 8'h0C;
  // Row i sits in bits 4i+3..4i
  localparam reg_addr_t REG_OPS_MASK    = 8'h10;
  // Write-only, bit 0 clears the accumulator
  localparam reg_addr_t REG_CLEAR       = 8'h14;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_engine_alu_ops -f sources.f -o tb_engine_alu_ops
./obj_dir/tb_engine_alu_ops > sim.log 2>&1
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"

// ==== sources.f ====
engine_alu_pkg.sv
engine_alu_ops_config.sv
engine_alu_ops_kernel.sv
engine_alu_ops_result_buffer.sv
engine_alu_ops_top.sv
tb_engine_alu_ops.sv

// ==== tb_engine_alu_ops.sv ====
// Testbench for the ALU stage with AXI4-Lite register tasks and random packets
// Reference model of crossbar, ALU and accumulator checked at the output
`timescale 1ns/1ns
`default_nettype none

module tb_engine_alu_ops;

  import engine_alu_pkg::*;

  localparam int FIFO_DEPTH     = 8;
  localparam int AXI_TIMEOUT    = 50;
  localparam int STREAM_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT  = 2000;

  logic           ap_clk = 1'b0;
  logic           areset;
  logic           awvalid;
  logic           awready;
  reg_addr_t      awaddr;
  logic           wvalid;
  logic           wready;
  logic [31:0]    wdata;
  logic           bvalid;
  logic           bready;
  logic [1:0]     bresp;
  logic           arvalid;
  logic           arready;
  reg_addr_t      araddr;
  logic           rvalid;
  logic           rready;
  logic [31:0]    rdata;
  logic [1:0]     rresp;
  logic           in_valid;
  logic           in_ready;
  engine_packet_t in_packet;
  logic           out_valid;
  logic           out_ready = 1'b0;
  engine_packet_t out_packet;

  // Output stall request from the back-pressure test
  logic           hold_output = 1'b0;

  // Shadow of the configuration registers
  logic [2:0]     sh_op;
  field_mask_t    sh_alu_mask;
  field_mask_t    sh_const_mask;
  field_t         sh_const_value;
  logic [15:0]    sh_ops_mask;
  field_t         model_acc;

  engine_packet_t expected_q [$];
  int             received;
  int             pass_count;
  int             fail_count;

  engine_alu_ops_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_packet  (in_packet),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_packet (out_packet)
  );

  // 40 ns clock
  always #20 ap_clk = ~ap_clk;

  // Output ready at about 70 percent unless held
  always begin
    @(posedge ap_clk);
    #2;
    out_ready = hold_output ? 1'b0 : (($urandom % 100) < 70);
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  task automatic check(input bit cond, input string msg);
    if (cond) pass_count++;
    assert (cond) else begin
      $display("Fail at %0t ns: %s", $time, msg);
      fail_count++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s at %0t ns", what, $time);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // Advance to the drive point after the next rising edge
  task automatic step();
    @(posedge ap_clk);
    #2;
  endtask

  task automatic axi_write(input reg_addr_t addr, input logic [31:0] data);
    int timer;
    timer   = 0;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(negedge ap_clk);
    while (!(awready && wready)) begin
      timer++;
      if (timer > AXI_TIMEOUT) stop_on_timeout("AXI write address and data");
      @(negedge ap_clk);
    end
    step();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    timer   = 0;
    @(negedge ap_clk);
    while (!bvalid) begin
      timer++;
      if (timer > AXI_TIMEOUT) stop_on_timeout("AXI write response");
      @(negedge ap_clk);
    end
    check(bresp == 2'b00, $sformatf("write response %0d at 0x%h", bresp, addr));
    step();
    bready = 1'b0;
  endtask

  task automatic axi_read(input reg_addr_t addr, output logic [31:0] data);
    int timer;
    timer   = 0;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge ap_clk);
    while (!arready) begin
      timer++;
      if (timer > AXI_TIMEOUT) stop_on_timeout("AXI read address");
      @(negedge ap_clk);
    end
    step();
    arvalid = 1'b0;
    timer   = 0;
    @(negedge ap_clk);
    while (!rvalid) begin
      timer++;
      if (timer > AXI_TIMEOUT) stop_on_timeout("AXI read data");
      @(negedge ap_clk);
    end
    data = rdata;
    check(rresp == 2'b00, $sformatf("read response %0d at 0x%h", rresp, addr));
    step();
    rready = 1'b0;
  endtask

  // Full register set, shadow follows
  task automatic configure(input logic [2:0] op, input field_mask_t alu_m,
                           input field_mask_t const_m, input field_t const_v,
                           input logic [15:0] ops_m);
    axi_write(REG_OPERATION, {29'd0, op});
    axi_write(REG_ALU_MASK, {28'd0, alu_m});
    axi_write(REG_CONST_MASK, {28'd0, const_m});
    axi_write(REG_CONST_VALUE, const_v);
    axi_write(REG_OPS_MASK, {16'd0, ops_m});
    sh_op          = op;
    sh_alu_mask    = alu_m;
    sh_const_mask  = const_m;
    sh_const_value = const_v;
    sh_ops_mask    = ops_m;
  endtask

  task automatic clear_accumulator();
    axi_write(REG_CLEAR, 32'h1);
    model_acc = '0;
  endtask

  function automatic engine_packet_t random_packet();
    engine_packet_t pkt;
    logic [31:0]    r;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      r                  = $urandom;
      pkt.field[i]       = $urandom;
      pkt.field_state[i] = field_state_t'(r[1:0]);
    end
    return pkt;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  task automatic predict(input engine_packet_t pkt);
    engine_packet_t opnd;
    engine_packet_t exp;
    int             src;
    int             pair_k;
    int             acc_k;
    field_t         a;
    field_t         b;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      opnd.field[i]       = '0;
      opnd.field_state[i] = SEQUENCE_INVALID;
      src                 = -1;
      // Highest set bit of row i wins
      for (int s = NUM_FIELDS - 1; s >= 0; s--) begin
        if (src < 0 && sh_ops_mask[NUM_FIELDS*i+s]) src = s;
      end
      if (sh_const_mask[i]) begin
        opnd.field[i]       = sh_const_value;
        opnd.field_state[i] = SEQUENCE_RUNNING;
      end else if (src >= 0) begin
        opnd.field[i]       = pkt.field[src];
        opnd.field_state[i] = pkt.field_state[src];
      end
    end
    pair_k = -1;
    acc_k  = -1;
    for (int s = NUM_FIELDS - 1; s >= 0; s--) begin
      if (acc_k < 0 && sh_alu_mask[s]) acc_k = s;
      if (pair_k < 0 && s < NUM_FIELDS - 1 && sh_alu_mask[s]) pair_k = s;
    end
    exp = opnd;
    if (pair_k >= 0) begin
      a = opnd.field[pair_k];
      b = opnd.field[pair_k+1];
    end
    case (sh_op)
      3'd1: if (pair_k >= 0) exp.field[0] = a + b;
      3'd2: if (pair_k >= 0) exp.field[0] = (a > b) ? a - b : b - a;
      3'd3: if (pair_k >= 0) exp.field[0] = a * b;
      3'd4: begin
        if (acc_k >= 0) model_acc = model_acc + opnd.field[acc_k];
        exp.field[0] = model_acc;
      end
      default: ;
    endcase
    expected_q.push_back(exp);
  endtask

  task automatic compare_output();
    engine_packet_t exp;
    received++;
    if (expected_q.size() == 0) begin
      check(1'b0, $sformatf("output packet %0d has no matching input", received));
    end else begin
      exp = expected_q.pop_front();
      check(out_packet == exp, $sformatf("packet %0d got %h expected %h",
                                         received, out_packet, exp));
    end
  endtask

  // Handshakes sampled mid-cycle, before the edge that completes them
  always @(negedge ap_clk) begin
    if (!areset) begin
      if (in_valid && in_ready) predict(in_packet);
      if (out_valid && out_ready) compare_output();
    end
  end

  // ----------------------------------------------------------------------
  // Stream tasks
  // ----------------------------------------------------------------------

  task automatic send_packets(input int count);
    int sent;
    int timer;
    sent = 0;
    while (sent < count) begin
      // Occasional idle cycle
      if ($urandom_range(3, 0) == 0) begin
        in_valid = 1'b0;
        step();
      end
      in_packet = random_packet();
      in_valid  = 1'b1;
      timer     = 0;
      @(negedge ap_clk);
      while (!in_ready) begin
        timer++;
        if (timer > STREAM_TIMEOUT) stop_on_timeout("input ready");
        @(negedge ap_clk);
      end
      sent++;
      step();
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int timer;
    timer = 0;
    @(negedge ap_clk);
    while (expected_q.size() != 0) begin
      timer++;
      if (timer > DRAIN_TIMEOUT) stop_on_timeout("the output to drain");
      @(negedge ap_clk);
    end
    step();
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("Test %s: %0d failed checks", name, fail_count - fails_before);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  task automatic test_register_access();
    int          fails_before;
    reg_addr_t   addr [5];
    logic [31:0] width_mask [5];
    logic [31:0] value;
    logic [31:0] rd;
    fails_before  = fail_count;
    addr[0]       = REG_OPERATION;
    addr[1]       = REG_CONST_VALUE;
    addr[2]       = REG_CONST_MASK;
    addr[3]       = REG_ALU_MASK;
    addr[4]       = REG_OPS_MASK;
    width_mask[0] = 32'h7;
    width_mask[1] = 32'hFFFF_FFFF;
    width_mask[2] = 32'hF;
    width_mask[3] = 32'hF;
    width_mask[4] = 32'hFFFF;
    for (int i = 0; i < 5; i++) begin
      value = $urandom;
      axi_write(addr[i], value);
      axi_read(addr[i], rd);
      check(rd == (value & width_mask[i]),
            $sformatf("register 0x%h read %h expected %h", addr[i], rd, value & width_mask[i]));
    end
    axi_read(REG_CLEAR, rd);
    check(rd == 32'h0, $sformatf("clear register read %h", rd));
    // Unmapped offsets ignore writes
    axi_write(8'h18, $urandom);
    axi_read(8'h18, rd);
    check(rd == 32'h0, $sformatf("unmapped 0x18 read %h", rd));
    axi_read(8'hFC, rd);
    check(rd == 32'h0, $sformatf("unmapped 0xFC read %h", rd));
    report_test("register access", fails_before);
  endtask

  task automatic test_crossbar();
    int          fails_before;
    logic [31:0] r;
    logic [15:0] ops_m;
    field_mask_t const_m;
    fails_before = fail_count;
    for (int c = 0; c < 5; c++) begin
      r       = $urandom;
      ops_m   = r[15:0];
      const_m = r[19:16];
      // Empty rows 0 and 3, multi-bit rows 1 and 2
      if (c == 0) begin
        ops_m   = 16'h06F0;
        const_m = 4'b0000;
      end
      if (c == 1) const_m = 4'b1010;
      configure(ALU_NOP, r[23:20], const_m, $urandom, ops_m);
      send_packets(20);
      wait_drain();
    end
    report_test("operand crossbar", fails_before);
  endtask

  task automatic test_arithmetic();
    int          fails_before;
    logic [31:0] r;
    field_mask_t alu_m;
    logic [2:0]  op_list [3];
    fails_before = fail_count;
    op_list[0]   = ALU_ADD;
    op_list[1]   = ALU_SUB;
    op_list[2]   = ALU_MUL;
    for (int o = 0; o < 3; o++) begin
      for (int c = 0; c < 5; c++) begin
        r     = $urandom;
        alu_m = r[3:0];
        if (c == 0) alu_m = 4'b0000;
        // Top field alone gives no pair
        if (c == 1) alu_m = 4'b1000;
        configure(op_list[o], alu_m, 4'b0000, $urandom, 16'h8421);
        send_packets(20);
        wait_drain();
      end
    end
    report_test("add sub mul", fails_before);
  endtask

  task automatic test_accumulate();
    int          fails_before;
    logic [31:0] r;
    fails_before = fail_count;
    r            = $urandom;
    configure(ALU_ACC, r[3:0] | 4'b0001, 4'b0000, 32'h0, 16'h8421);
    clear_accumulator();
    send_packets(50);
    wait_drain();
    // Sum restarts from zero
    clear_accumulator();
    send_packets(1);
    wait_drain();
    report_test("accumulate and clear", fails_before);
  endtask

  task automatic test_nop_like();
    int          fails_before;
    logic [31:0] r;
    fails_before = fail_count;
    for (int op = 5; op < 8; op++) begin
      r = $urandom;
      configure(3'(op), r[3:0] | 4'b0010, r[7:4], $urandom, r[31:16]);
      send_packets(20);
      wait_drain();
    end
    report_test("div and unused codes", fails_before);
  endtask

  task automatic test_backpressure();
    int fails_before;
    int accepted;
    int fall_cycle;
    int rx_start;
    int seq;
    bit need_new;
    fails_before = fail_count;
    configure(ALU_NOP, 4'h0, 4'h0, 32'h0, 16'h8421);
    hold_output = 1'b1;
    step();
    step();
    rx_start   = received;
    accepted   = 0;
    fall_cycle = -1;
    seq        = 0;
    need_new   = 1'b1;
    // Sequence number in field 1 exposes loss and reordering
    for (int c = 0; c < 40; c++) begin
      if (need_new) begin
        in_packet          = random_packet();
        in_packet.field[1] = field_t'(seq);
        seq++;
      end
      in_valid = 1'b1;
      @(negedge ap_clk);
      need_new = in_ready;
      if (in_ready) begin
        accepted++;
      end else if (fall_cycle < 0) begin
        fall_cycle = c;
      end
      step();
    end
    in_valid = 1'b0;
    check(fall_cycle >= 0 && fall_cycle <= FIFO_DEPTH,
          $sformatf("input ready fell at cycle %0d", fall_cycle));
    check(accepted == FIFO_DEPTH, $sformatf("%0d packets accepted while stalled", accepted));
    hold_output = 1'b0;
    wait_drain();
    repeat (5) step();
    check(received - rx_start == accepted,
          $sformatf("%0d packets out for %0d in", received - rx_start, accepted));
    report_test("back-pressure", fails_before);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(32'h18ef7303));
    areset     = 1'b1;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    in_valid   = 1'b0;
    in_packet  = '0;
    sh_op          = '0;
    sh_alu_mask    = '0;
    sh_const_mask  = '0;
    sh_const_value = '0;
    sh_ops_mask    = '0;
    model_acc  = '0;
    received   = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (8) @(posedge ap_clk);
    #2;
    areset = 1'b0;
    step();
    test_register_access();
    test_crossbar();
    test_arithmetic();
    test_accumulate();
    test_nop_like();
    test_backpressure();
    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
